// ==== logic/decode_defines.svh ====
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

////////////////////
// Widths
`define XLEN        32
`define REG_ADDR_W  5
`define ID_W        3

////////////////////
// Execution units and credits
`define NUM_UNITS     4
`define UNIT_CREDITS  2
`define CREDIT_W      2

`define UNIT_BRANCH  0
`define UNIT_ALU     1
`define UNIT_LS      2
`define UNIT_SYS     3

////////////////////
// RV32I opcodes, bits [6:2] only
`define OP_LUI        5'b01101
`define OP_AUIPC      5'b00101
`define OP_JAL        5'b11011
`define OP_JALR       5'b11001
`define OP_BRANCH     5'b11000
`define OP_LOAD       5'b00000
`define OP_STORE      5'b01000
`define OP_ARITH_IMM  5'b00100
`define OP_ARITH      5'b01100
`define OP_FENCE      5'b00011
`define OP_SYSTEM     5'b11100

////////////////////
// Arithmetic fn3 codes
`define FN3_ADD_SUB  3'b000
`define FN3_SLL      3'b001
`define FN3_SLT      3'b010
`define FN3_SLTU     3'b011
`define FN3_XOR      3'b100
`define FN3_SRL_SRA  3'b101
`define FN3_OR       3'b110
`define FN3_AND      3'b111

`endif

// ==== logic/decode_pkg.sv ====
`include "decode_defines.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0]       data_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ID_W-1:0]       id_t;
    typedef logic [`NUM_UNITS-1:0]  unit_mask_t;
    typedef logic [`CREDIT_W-1:0]   credit_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_t;

    ////////////////////
    // Fetch side
    typedef struct packed {
        data_t instruction;
        data_t pc;
        id_t   id;
    } fetch_packet_t;

    ////////////////////
    // Decoded instruction, as held in the issue stage
    typedef struct packed {
        data_t       pc;
        id_t         id;
        reg_addr_t   rs1_addr;
        reg_addr_t   rs2_addr;
        reg_addr_t   rd_addr;
        logic        uses_rs1;
        logic        uses_rs2;
        logic        uses_rd;
        unit_mask_t  unit;
        alu_op_t     alu_op;
        // ALU operand sources
        logic        alu_in1_pc;
        logic        alu_in1_zero;
        logic        alu_in2_imm;
        data_t       alu_imm;
        logic [11:0] ls_offset;
        logic [20:0] branch_offset;
    } decoded_t;

    ////////////////////
    // Packet presented to the units on issue
    typedef struct packed {
        unit_mask_t  unit;
        id_t         id;
        data_t       pc;
        reg_addr_t   rd_addr;
        logic        uses_rd;
        alu_op_t     alu_op;
        data_t       alu_in1;
        data_t       alu_in2;
        logic [11:0] ls_offset;
        logic [20:0] branch_offset;
        data_t       rs1_data;
        data_t       rs2_data;
    } issue_packet_t;

endpackage

// ==== logic/instruction_decoder.sv ====
`include "decode_defines.svh"

module instruction_decoder (
    input  decode_pkg::data_t    instruction,
    input  decode_pkg::data_t    pc,
    input  decode_pkg::id_t      id,
    output decode_pkg::decoded_t decoded
);
    import decode_pkg::*;

    logic [4:0] opcode;
    logic [2:0] fn3;

    logic is_lui;
    logic is_auipc;
    logic is_jal;
    logic is_jalr;
    logic is_branch;
    logic is_load;
    logic is_store;
    logic is_arith_imm;
    logic is_arith;
    logic is_fence;
    logic is_system;

    logic csr_imm_op;
    logic environment_op;

    alu_op_t     alu_op;
    data_t       i_imm;
    logic [20:0] jal_offset;
    logic [20:0] jalr_offset;
    logic [20:0] br_offset;

    ////////////////////
    // Field slicing
    assign opcode = instruction[6:2];
    assign fn3    = instruction[14:12];

    assign is_lui       = (opcode == `OP_LUI);
    assign is_auipc     = (opcode == `OP_AUIPC);
    assign is_jal       = (opcode == `OP_JAL);
    assign is_jalr      = (opcode == `OP_JALR);
    assign is_branch    = (opcode == `OP_BRANCH);
    assign is_load      = (opcode == `OP_LOAD);
    assign is_store     = (opcode == `OP_STORE);
    assign is_arith_imm = (opcode == `OP_ARITH_IMM);
    assign is_arith     = (opcode == `OP_ARITH);
    assign is_fence     = (opcode == `OP_FENCE);
    assign is_system    = (opcode == `OP_SYSTEM);

    // CSR immediate forms and ECALL/EBREAK/xRET read no rs1
    assign csr_imm_op     = is_system & fn3[2];
    assign environment_op = is_system & (fn3 == 3'b000);

    ////////////////////
    // ALU operation
    always_comb begin
        alu_op = ALU_ADD;
        if (is_arith | is_arith_imm) begin
            case (fn3)
                `FN3_ADD_SUB: alu_op = (is_arith & instruction[30]) ? ALU_SUB : ALU_ADD;
                `FN3_SLL:     alu_op = ALU_SLL;
                `FN3_SLT:     alu_op = ALU_SLT;
                `FN3_SLTU:    alu_op = ALU_SLTU;
                `FN3_XOR:     alu_op = ALU_XOR;
                `FN3_SRL_SRA: alu_op = instruction[30] ? ALU_SRA : ALU_SRL;
                `FN3_OR:      alu_op = ALU_OR;
                `FN3_AND:     alu_op = ALU_AND;
            endcase
        end
    end

    ////////////////////
    // Immediates
    assign i_imm = {{20{instruction[31]}}, instruction[31:20]};

    assign jal_offset = {instruction[31], instruction[19:12], instruction[20],
                         instruction[30:21], 1'b0};
    assign jalr_offset = {{9{instruction[31]}}, instruction[31:20]};
    assign br_offset = {{8{instruction[31]}}, instruction[31], instruction[7],
                        instruction[30:25], instruction[11:8], 1'b0};

    always_comb begin
        decoded          = '0;
        decoded.pc       = pc;
        decoded.id       = id;
        decoded.rs1_addr = instruction[19:15];
        decoded.rs2_addr = instruction[24:20];
        decoded.rd_addr  = instruction[11:7];

        decoded.uses_rs1 = ~(is_lui | is_auipc | is_jal | is_fence | csr_imm_op | environment_op);
        decoded.uses_rs2 = is_branch | is_store | is_arith;
        decoded.uses_rd  = ~(is_branch | is_store | is_fence | environment_op);

        // Jumps go to both branch and ALU, the ALU writes the link address
        decoded.unit[`UNIT_BRANCH] = is_branch | is_jal | is_jalr;
        decoded.unit[`UNIT_ALU]    = is_lui | is_auipc | is_jal | is_jalr | is_arith_imm |
                                     (is_arith & ~instruction[25]);
        decoded.unit[`UNIT_LS]     = is_load | is_store;
        decoded.unit[`UNIT_SYS]    = is_system | is_fence;

        decoded.alu_op       = alu_op;
        decoded.alu_in1_pc   = is_auipc | is_jal | is_jalr;
        decoded.alu_in1_zero = is_lui;
        decoded.alu_in2_imm  = is_lui | is_auipc | is_jal | is_jalr | is_arith_imm;

        if (is_lui | is_auipc)
            decoded.alu_imm = {instruction[31:12], 12'b0};
        else if (is_jal | is_jalr)
            decoded.alu_imm = 32'd4;
        else
            decoded.alu_imm = i_imm;

        // S form for stores, I form for loads
        decoded.ls_offset = is_store ? {instruction[31:25], instruction[11:7]} :
                                       instruction[31:20];

        if (is_jal)
            decoded.branch_offset = jal_offset;
        else if (is_jalr)
            decoded.branch_offset = jalr_offset;
        else
            decoded.branch_offset = br_offset;
    end

endmodule

// ==== logic/unit_credit_tracker.sv ====
`include "decode_defines.svh"

module unit_credit_tracker (
    input  logic clk,
    input  logic rst,
    input  logic take,
    input  logic give,
    output logic available
);
    import decode_pkg::*;

    credit_t count;

    ////////////////////
    // Credit count
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= credit_t'(`UNIT_CREDITS);
        end else begin
            case ({take, give})
                2'b10:   count <= count - credit_t'(1);
                2'b01:   count <= count + credit_t'(1);
                // Issue and return in the same cycle cancel out
                default: count <= count;
            endcase
        end
    end

    assign available = (count != '0);

endmodule

// ==== logic/issue_stage.sv ====
module issue_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  decode_pkg::decoded_t   decoded,
    output logic                   decode_ready,
    input  logic                   flush,
    input  logic                   issue_hold,
    input  logic                   rs1_inuse,
    input  logic                   rs2_inuse,
    input  decode_pkg::unit_mask_t unit_available,
    output decode_pkg::decoded_t   held,
    output logic                   issue_valid,
    output decode_pkg::unit_mask_t issue_unit,
    output logic                   illegal
);
    import decode_pkg::*;

    logic stage_valid;
    logic no_unit;
    logic operands_ready;
    logic credits_ready;
    logic can_leave;

    ////////////////////
    // Stage register
    always_ff @(posedge clk) begin
        if (rst)
            stage_valid <= 1'b0;
        else if (flush)
            stage_valid <= 1'b0;
        else if (decode_ready)
            stage_valid <= fetch_valid;
    end

    always_ff @(posedge clk) begin
        if (decode_ready & fetch_valid)
            held <= decoded;
    end

    ////////////////////
    // Issue decision

    // An inuse flag blocks only when the source is actually read
    assign operands_ready = ~(rs1_inuse & held.uses_rs1) & ~(rs2_inuse & held.uses_rs2);

    // Every unit named in the mask needs a credit
    assign credits_ready = &(unit_available | ~held.unit);

    assign no_unit   = (held.unit == '0);
    assign can_leave = stage_valid & ~issue_hold & ~flush;

    assign issue_valid = can_leave & ~no_unit & operands_ready & credits_ready;
    assign issue_unit  = held.unit & {$bits(unit_mask_t){issue_valid}};

    // Unsupported instructions retire without waiting on operands or credits
    assign illegal = can_leave & no_unit;

    ////////////////////
    // Back-pressure toward decode
    assign decode_ready = ~issue_hold & ~flush & (~stage_valid | issue_valid | illegal);

endmodule

// ==== logic/operand_formatter.sv ====
module operand_formatter (
    input  decode_pkg::decoded_t      held,
    input  decode_pkg::unit_mask_t    issue_unit,
    input  decode_pkg::data_t         rs1_data,
    input  decode_pkg::data_t         rs2_data,
    output decode_pkg::issue_packet_t issue
);
    import decode_pkg::*;

    data_t alu_in1;
    data_t alu_in2;

    ////////////////////
    // ALU operands

    // pc for AUIPC and jumps, zero for LUI
    always_comb begin
        if (held.alu_in1_pc)
            alu_in1 = held.pc;
        else if (held.alu_in1_zero)
            alu_in1 = '0;
        else
            alu_in1 = rs1_data;
    end

    assign alu_in2 = held.alu_in2_imm ? held.alu_imm : rs2_data;

    ////////////////////
    // Packet assembly
    always_comb begin
        issue.unit          = issue_unit;
        issue.id            = held.id;
        issue.pc            = held.pc;
        issue.rd_addr       = held.rd_addr;
        issue.uses_rd       = held.uses_rd;
        issue.alu_op        = held.alu_op;
        issue.alu_in1       = alu_in1;
        issue.alu_in2       = alu_in2;
        issue.ls_offset     = held.ls_offset;
        issue.branch_offset = held.branch_offset;
        // Raw register values for branch compare, store data and CSR writes
        issue.rs1_data      = rs1_data;
        issue.rs2_data      = rs2_data;
    end

endmodule

// ==== logic/decode_issue.sv ====
`include "decode_defines.svh"

module decode_issue (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      fetch_valid,
    input  decode_pkg::fetch_packet_t fetch,
    output logic                      decode_ready,
    output decode_pkg::reg_addr_t     rs1_addr,
    output decode_pkg::reg_addr_t     rs2_addr,
    input  decode_pkg::data_t         rs1_data,
    input  decode_pkg::data_t         rs2_data,
    input  logic                      rs1_inuse,
    input  logic                      rs2_inuse,
    input  logic                      flush,
    input  logic                      issue_hold,
    input  decode_pkg::unit_mask_t    credit_return,
    output logic                      issue_valid,
    output decode_pkg::issue_packet_t issue,
    output logic                      illegal
);
    import decode_pkg::*;

    decoded_t   decoded;
    decoded_t   held;
    unit_mask_t issue_unit;
    unit_mask_t unit_available;

    instruction_decoder i_decoder (
        .instruction (fetch.instruction),
        .pc          (fetch.pc),
        .id          (fetch.id),
        .decoded     (decoded)
    );

    issue_stage i_issue_stage (
        .clk            (clk),
        .rst            (rst),
        .fetch_valid    (fetch_valid),
        .decoded        (decoded),
        .decode_ready   (decode_ready),
        .flush          (flush),
        .issue_hold     (issue_hold),
        .rs1_inuse      (rs1_inuse),
        .rs2_inuse      (rs2_inuse),
        .unit_available (unit_available),
        .held           (held),
        .issue_valid    (issue_valid),
        .issue_unit     (issue_unit),
        .illegal        (illegal)
    );

    // Register file reads come from the held instruction
    assign rs1_addr = held.rs1_addr;
    assign rs2_addr = held.rs2_addr;

    operand_formatter i_formatter (
        .held       (held),
        .issue_unit (issue_unit),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .issue      (issue)
    );

    ////////////////////
    // One credit counter per unit
    for (genvar u = 0; u < `NUM_UNITS; u++) begin : g_credit
        unit_credit_tracker i_tracker (
            .clk       (clk),
            .rst       (rst),
            .take      (issue_unit[u]),
            .give      (credit_return[u]),
            .available (unit_available[u])
        );
    end

endmodule

// ==== dv/decode_issue_tb.sv ====
`include "decode_defines.svh"

module decode_issue_tb;
    import decode_pkg::*;

    localparam int NUM_INSTR   = 400;
    localparam int CYCLE_LIMIT = 20 * NUM_INSTR + 100;
    // Window with credit returns stopped
    localparam int HALT_START  = 300;
    localparam int HALT_END    = 360;
    // Supported opcodes with extra ARITH weight, then three unsupported ones
    localparam logic [4:0] OPCODES [16] = '{
        `OP_LUI, `OP_AUIPC, `OP_JAL, `OP_JALR, `OP_BRANCH, `OP_LOAD, `OP_STORE, `OP_ARITH_IMM,
        `OP_ARITH, `OP_ARITH, `OP_FENCE, `OP_SYSTEM, `OP_ARITH_IMM, 5'b01011, 5'b10100, 5'b00001
    };

    typedef struct packed {
        logic          illegal;
        logic          uses_rs1;
        logic          uses_rs2;
        reg_addr_t     rs1_addr;
        reg_addr_t     rs2_addr;
        issue_packet_t pkt;
    } expect_t;

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    logic          fetch_valid = 1'b0;
    fetch_packet_t fetch = '0;
    logic          decode_ready;
    reg_addr_t     rs1_addr;
    reg_addr_t     rs2_addr;
    data_t         rs1_data = '0;
    data_t         rs2_data = '0;
    logic          rs1_inuse = 1'b0;
    logic          rs2_inuse = 1'b0;
    logic          flush = 1'b0;
    logic          issue_hold = 1'b0;
    unit_mask_t    credit_return = '0;
    logic          issue_valid;
    issue_packet_t issue;
    logic          illegal;

    logic [31:0] rng_state = 32'd47465;
    data_t       regs [2**`REG_ADDR_W];
    int          credits [`NUM_UNITS];
    expect_t     pending [$];
    int          cycle = 0;
    int          accepted = 0;
    id_t         next_id = '0;
    logic        fetch_taken = 1'b0;

    decode_issue i_dut (.*);

    always #50 clk = ~clk;

    ////////////////////
    // Helpers

    function automatic logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic alu_op_t arith_op(input logic [2:0] fn3, input logic sub,
                                         input logic shift_arith);
        case (fn3)
            3'd0:    return sub ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return shift_arith ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Expected packet and hazard flags for one instruction
    function automatic expect_t predict_issue(input data_t instr, input data_t pc, input id_t id,
                                              input data_t rs1_val, input data_t rs2_val);
        expect_t    e;
        logic [2:0] fn3;
        fn3 = instr[14:12];
        e = '0;
        e.uses_rs1 = 1'b1;
        e.rs1_addr = instr[19:15];
        e.rs2_addr = instr[24:20];
        e.pkt.id = id;
        e.pkt.pc = pc;
        e.pkt.rd_addr = instr[11:7];
        e.pkt.uses_rd = 1'b1;
        e.pkt.alu_op = ALU_ADD;
        e.pkt.alu_in1 = rs1_val;
        e.pkt.alu_in2 = rs2_val;
        e.pkt.ls_offset = instr[31:20];
        e.pkt.branch_offset = {{8{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8],
                               1'b0};
        e.pkt.rs1_data = rs1_val;
        e.pkt.rs2_data = rs2_val;
        case (instr[6:2])
            `OP_LUI, `OP_AUIPC: begin
                e.pkt.unit[`UNIT_ALU] = 1'b1;
                e.uses_rs1 = 1'b0;
                e.pkt.alu_in1 = (instr[6:2] == `OP_LUI) ? '0 : pc;
                e.pkt.alu_in2 = {instr[31:12], 12'b0};
            end
            `OP_JAL, `OP_JALR: begin
                // Link address pc + 4 goes through the ALU
                e.pkt.unit[`UNIT_BRANCH] = 1'b1;
                e.pkt.unit[`UNIT_ALU] = 1'b1;
                e.pkt.alu_in1 = pc;
                e.pkt.alu_in2 = 32'd4;
                e.uses_rs1 = (instr[6:2] == `OP_JALR);
                e.pkt.branch_offset = e.uses_rs1 ? {{9{instr[31]}}, instr[31:20]} :
                    {instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            `OP_BRANCH: begin
                e.pkt.unit[`UNIT_BRANCH] = 1'b1;
                e.uses_rs2 = 1'b1;
                e.pkt.uses_rd = 1'b0;
            end
            `OP_LOAD: e.pkt.unit[`UNIT_LS] = 1'b1;
            `OP_STORE: begin
                e.pkt.unit[`UNIT_LS] = 1'b1;
                e.uses_rs2 = 1'b1;
                e.pkt.uses_rd = 1'b0;
                e.pkt.ls_offset = {instr[31:25], instr[11:7]};
            end
            `OP_ARITH_IMM: begin
                e.pkt.unit[`UNIT_ALU] = 1'b1;
                e.pkt.alu_op = arith_op(fn3, 1'b0, instr[30]);
                e.pkt.alu_in2 = {{20{instr[31]}}, instr[31:20]};
            end
            `OP_ARITH: begin
                // Bit 25 selects the multiply/divide group, which has no unit
                e.pkt.unit[`UNIT_ALU] = ~instr[25];
                e.uses_rs2 = 1'b1;
                e.pkt.alu_op = arith_op(fn3, instr[30], instr[30]);
            end
            `OP_FENCE, `OP_SYSTEM: begin
                e.pkt.unit[`UNIT_SYS] = 1'b1;
                // FENCE, ECALL class and CSR immediates read no rs1
                e.uses_rs1 = (instr[6:2] == `OP_SYSTEM) && (fn3 != 3'b000) && !fn3[2];
                e.pkt.uses_rd = (instr[6:2] == `OP_SYSTEM) && (fn3 != 3'b000);
            end
            default: ;
        endcase
        e.illegal = (e.pkt.unit == '0);
        return e;
    endfunction

    task automatic report_error(input string msg);
        $display("error at time %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    ////////////////////
    // Stimulus on the falling edge
    always @(negedge clk) begin : drive
        logic [31:0] r;
        logic [31:0] s;
        rst = (cycle < 5);
        if (cycle == 1) begin
            for (int a = 0; a < 2**`REG_ADDR_W; a++)
                regs[a] = (a == 0) ? '0 : xorshift32();
        end
        if (cycle == 5) begin
            assert (decode_ready && !issue_valid && !illegal)
                else report_error("stage not empty and ready right after reset");
        end
        if (!rst) begin
            // Register file answers for the held instruction
            rs1_data = regs[rs1_addr];
            rs2_data = regs[rs2_addr];
            r = xorshift32();
            rs1_inuse = (r[1:0] == 2'b00);
            rs2_inuse = (r[3:2] == 2'b00);
            issue_hold = (cycle > 8) && (r[6:4] == 3'b000);
            flush = (cycle > 8) && (r[11:7] == 5'b00000);
            for (int u = 0; u < `NUM_UNITS; u++)
                credit_return[u] = (cycle < HALT_START || cycle >= HALT_END) &&
                                   credits[u] < `UNIT_CREDITS && r[13 + 2*u +: 2] == 2'b00;
            // Fetch packet stays put until it is taken
            if (!fetch_valid || fetch_taken) begin
                s = xorshift32();
                fetch_valid = (accepted < NUM_INSTR) && (r[22:21] != 2'b00);
                fetch.instruction = {s[31:7], OPCODES[r[26:23]], 2'b11};
                fetch.pc = xorshift32() & 32'hFFFF_FFFC;
                fetch.id = next_id;
                next_id = next_id + id_t'(fetch_valid);
            end
        end
    end

    ////////////////////
    // Checks and model update
    always @(posedge clk) begin : compare
        expect_t front;
        logic    busy;
        logic    credit_ok;
        logic    exp_issue;
        logic    exp_illegal;
        logic    exp_ready;
        cycle = cycle + 1;
        fetch_taken = 1'b0;
        if (cycle > CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end else if (rst) begin
            pending.delete();
            for (int u = 0; u < `NUM_UNITS; u++)
                credits[u] = `UNIT_CREDITS;
        end else begin
            busy = (pending.size() != 0);
            front = busy ? pending[0] : '0;
            credit_ok = 1'b1;
            for (int u = 0; u < `NUM_UNITS; u++)
                if (front.pkt.unit[u] && credits[u] == 0)
                    credit_ok = 1'b0;
            exp_illegal = busy && !issue_hold && !flush && front.illegal;
            exp_issue = busy && !issue_hold && !flush && !front.illegal && credit_ok &&
                        !(rs1_inuse && front.uses_rs1) && !(rs2_inuse && front.uses_rs2);
            exp_ready = !issue_hold && !flush && (!busy || exp_issue || exp_illegal);
            assert (issue_valid == exp_issue)
                else report_error($sformatf("issue_valid %b, want %b", issue_valid, exp_issue));
            assert (illegal == exp_illegal)
                else report_error($sformatf("illegal %b, want %b", illegal, exp_illegal));
            assert (decode_ready == exp_ready)
                else report_error($sformatf("decode_ready %b, want %b", decode_ready, exp_ready));
            // Register file addresses follow the held instruction
            if (busy) begin
                assert (rs1_addr == front.rs1_addr && rs2_addr == front.rs2_addr)
                    else report_error($sformatf("register reads %0d and %0d, want %0d and %0d",
                        rs1_addr, rs2_addr, front.rs1_addr, front.rs2_addr));
            end
            if (issue_valid) begin
                assert (issue == front.pkt) else report_error($sformatf(
                    "packet for id %0d is %h, want %h", front.pkt.id, issue, front.pkt));
            end
            // Front entry leaves on issue, illegal retire or flush
            if (issue_valid || illegal || (flush && busy))
                void'(pending.pop_front());
            for (int u = 0; u < `NUM_UNITS; u++)
                credits[u] = credits[u] - int'(exp_issue && front.pkt.unit[u]) +
                             int'(credit_return[u]);
            if (fetch_valid && decode_ready) begin
                pending.push_back(predict_issue(fetch.instruction, fetch.pc, fetch.id,
                    regs[fetch.instruction[19:15]], regs[fetch.instruction[24:20]]));
                accepted = accepted + 1;
                fetch_taken = 1'b1;
            end
        end
    end

    // Run ends once every instruction has left the stage
    initial begin
        do
            @(negedge clk);
        while (accepted < NUM_INSTR || pending.size() != 0);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== decode_issue.f ====
+incdir+logic
logic/decode_pkg.sv
logic/instruction_decoder.sv
logic/unit_credit_tracker.sv
logic/issue_stage.sv
logic/operand_formatter.sv
logic/decode_issue.sv
dv/decode_issue_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the decode and issue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module decode_issue_tb \
    -f decode_issue.f -o decode_issue_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/decode_issue_sim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "Simulation FAILED"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
